/* aesCore/aesCipherCore.sv */
/*
 * Iterative AES-128 encrypt core, one round per clock,
 * result held with done until cleared
 */
`timescale 1ns/1ps

module aesCipherCore import aesPkg::*; (
    input  logic      Clock,
    input  logic      rstN,
    input  logic      load,
    input  logic      clear,
    input  aesBlockT  block,
    input  roundKeysT roundKeys,
    output logic      done,
    output aesBlockT  result
);

    aesBlockT             state;
    logic [RoundBits-1:0] round;
    logic                 busy;

    // ----------------------------------------
    // Round sequencing
    // ----------------------------------------
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            busy  <= 1'b0;
            done  <= 1'b0;
            round <= '0;
        end else if (load) begin
            // Load cycle is round 0
            busy  <= 1'b1;
            done  <= 1'b0;
            round <= RoundBits'(1);
        end else if (clear) begin
            busy  <= 1'b0;
            done  <= 1'b0;
            round <= '0;
        end else if (busy) begin
            if (round == LastRound) begin
                // Counter parks at the last round
                busy <= 1'b0;
                done <= 1'b1;
            end else begin
                round <= round + 1'b1;
            end
        end
    end

    // ----------------------------------------
    // State datapath
    // ----------------------------------------
    always_ff @(posedge Clock) begin
        if (load) begin
            // Initial AddRoundKey
            state <= block ^ roundKeys[0];
        end else if (busy) begin
            state <= subShiftMix(state, roundKeys[round], round == LastRound);
        end
    end

    // Holds after done until the slot is released
    assign result = state;

    // Slot logic must never reload a running core
    noLoadWhileBusy: assert property (
        @(posedge Clock) disable iff (!rstN)
        load |-> !busy
    );

    // Result ready exactly 11 cycles after the load cycle
    doneAfterRounds: assert property (
        @(posedge Clock) disable iff (!rstN)
        load |-> ##11 $rose(done)
    );

endmodule

/* aesCore/aesKeyExpand.sv */
/*
 * AES-128 key expander, one round key per clock,
 * holds all eleven round keys for the cipher cores
 */
`timescale 1ns/1ps

module aesKeyExpand import aesPkg::*; (
    input  logic      Clock,
    input  logic      rstN,
    input  aesBlockT  key,
    input  logic      keyValid,
    input  logic      slotsEmpty,
    output logic      keyReady,
    output logic      keyLoaded,
    output roundKeysT roundKeys
);

    logic                 expBusy;
    logic [RoundBits-1:0] roundIdx;
    logic [7:0]           rcon;
    logic                 keyAccept;

    // Loads only between streams
    assign keyReady  = !expBusy && slotsEmpty;
    assign keyAccept = keyValid && keyReady;

    // ----------------------------------------
    // Schedule control
    // ----------------------------------------
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            expBusy   <= 1'b0;
            keyLoaded <= 1'b0;
            roundIdx  <= '0;
            rcon      <= '0;
        end else if (keyAccept) begin
            expBusy   <= 1'b1;
            keyLoaded <= 1'b0;
            roundIdx  <= RoundBits'(1);
            rcon      <= RconInit;
        end else if (expBusy) begin
            rcon <= xtime(rcon);
            if (roundIdx == LastRound) begin
                // Round key 10 lands on this edge
                expBusy   <= 1'b0;
                keyLoaded <= 1'b1;
            end else begin
                roundIdx <= roundIdx + 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Round key store
    // ----------------------------------------
    always_ff @(posedge Clock) begin
        if (keyAccept) begin
            roundKeys[0] <= key;
        end else if (expBusy) begin
            roundKeys[roundIdx] <= nextRoundKey(roundKeys[roundIdx - 1'b1], rcon);
        end
    end

    // keyLoaded rises in the 11th cycle after a load
    keyScheduleLength: assert property (
        @(posedge Clock) disable iff (!rstN)
        keyAccept |-> ##11 $rose(keyLoaded)
    );

endmodule

/* common/aesPkg.sv */
/*
 * AES-128 package: block and round-key types, S-box table,
 * and the round-step and key-schedule functions
 */
package aesPkg;

    // ----------------------------------------
    // Sizes
    // ----------------------------------------
    localparam int AesBlockBits = 128;
    localparam int AesRounds    = 10;
    localparam int RoundBits    = $clog2(AesRounds + 1);

    localparam logic [RoundBits-1:0] LastRound = RoundBits'(AesRounds);
    // First round constant of the key schedule
    localparam logic [7:0] RconInit = 8'h01;

    // Byte 0 sits in bits 127:120, columns are 32 bits each
    typedef logic [AesBlockBits-1:0] aesBlockT;
    // Index equals round number, 0 is the raw key
    typedef aesBlockT [AesRounds:0] roundKeysT;

    // ----------------------------------------
    // Forward S-box, entry 0 leftmost
    // ----------------------------------------
    localparam logic [0:255][7:0] SboxTable = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    function automatic logic [7:0] sbox(input logic [7:0] x);
        return SboxTable[x];
    endfunction

    // Multiply by 2 in GF(2^8), reduction polynomial 0x11b
    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // One full round: SubBytes, ShiftRows, MixColumns, AddRoundKey
    // MixColumns skipped in the final round
    function automatic aesBlockT subShiftMix(
        input aesBlockT state,
        input aesBlockT roundKey,
        input logic     lastRound
    );
        logic [7:0] sb [16];
        logic [7:0] a0, a1, a2, a3;
        aesBlockT   mixed;
        int         src;
        // Row r of column c reads column c+r of the input
        for (int i = 0; i < 16; i++) begin
            src   = (i % 4) + 4 * (((i / 4) + (i % 4)) % 4);
            sb[i] = sbox(state[127 - 8*src -: 8]);
        end
        for (int c = 0; c < 4; c++) begin
            a0 = sb[4*c];
            a1 = sb[4*c + 1];
            a2 = sb[4*c + 2];
            a3 = sb[4*c + 3];
            if (lastRound) begin
                mixed[127 - 32*c -: 32] = {a0, a1, a2, a3};
            end else begin
                // Fixed 02 03 01 01 circulant
                mixed[127 - 32*c -: 32] = {
                    xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
                    a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
                    a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
                    xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)
                };
            end
        end
        return mixed ^ roundKey;
    endfunction

    // AES-128 key schedule step, four words per call
    function automatic aesBlockT nextRoundKey(
        input aesBlockT   prevKey,
        input logic [7:0] rcon
    );
        logic [31:0] w0, w1, w2, w3, t;
        w0 = prevKey[127:96];
        w1 = prevKey[95:64];
        w2 = prevKey[63:32];
        w3 = prevKey[31:0];
        // RotWord then SubWord, rcon into the top byte
        t  = {sbox(w3[23:16]), sbox(w3[15:8]), sbox(w3[7:0]), sbox(w3[31:24])};
        t  = t ^ {rcon, 24'h000000};
        w0 = w0 ^ t;
        w1 = w1 ^ w0;
        w2 = w2 ^ w1;
        w3 = w3 ^ w2;
        return {w0, w1, w2, w3};
    endfunction

endpackage

/* common/streamPkg.sv */
/*
 * Keystream package: slot and lane geometry, credit depth,
 * counter request and output word types
 */
package streamPkg;
    import aesPkg::*;

    // ----------------------------------------
    // Geometry
    // ----------------------------------------
    localparam int LaneCount   = 2;
    localparam int SlotCount   = 4;
    localparam int CtrBits     = 64;
    localparam int CreditMax   = 4;
    localparam int SeqBits     = 16;
    localparam int SlotIdxBits = $clog2(SlotCount);
    // Must hold the value CreditMax itself
    localparam int CreditBits  = $clog2(CreditMax + 1);

    // Counter base from the host
    typedef struct packed {
        logic [CtrBits-1:0] ctrBase;
    } ctrReqT;

    // One released word, lane j in blocks[j]
    typedef struct packed {
        aesBlockT [LaneCount-1:0] blocks;
        logic [SeqBits-1:0]       seq;
    } streamWordT;

endpackage

/* filelist.f */
+incdir+verif
common/aesPkg.sv
common/streamPkg.sv
aesCore/aesKeyExpand.sv
aesCore/aesCipherCore.sv
verilog/keystreamSlots.sv
verilog/keystreamTop.sv
verif/tbKeystream.sv

/* run.sh */
#!/bin/sh
# Build and run the keystream testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tbKeystream -f filelist.f -o simKeystream
./obj_dir/simKeystream > sim.log 2>&1 || true
cat sim.log
if grep -q "Result: FAILED" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"

/* verif/aesModel.svh */
/*
 * Behavioral AES-128 encrypt model and counter-block helper,
 * S-box built from the GF(2^8) inverse and the affine map
 */
`ifndef aesModelSvh
`define aesModelSvh

// GF(2^8) product, reduction polynomial 0x11b
function automatic logic [7:0] gfMul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] p;
    logic [7:0] x;
    p = 8'h00;
    x = a;
    for (int i = 0; i < 8; i++) begin
        if (b[i]) begin
            p = p ^ x;
        end
        x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
    end
    return p;
endfunction

function automatic logic [7:0] sboxByInverse(input logic [7:0] x);
    logic [7:0] inv;
    inv = 8'h01;
    // Inverse as x^254, zero stays zero
    for (int i = 0; i < 254; i++) begin
        inv = gfMul(inv, x);
    end
    return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^ {inv[4:0], inv[7:5]}
        ^ {inv[3:0], inv[7:4]} ^ 8'h63;
endfunction

function automatic logic [127:0] encryptBlock(input logic [127:0] key, input logic [127:0] pt);
    logic [31:0]  w [44];
    logic [7:0]   s [16];
    logic [7:0]   t [16];
    logic [31:0]  tmp;
    logic [7:0]   rc;
    logic [127:0] res;
    // Word-wise key schedule
    for (int i = 0; i < 4; i++) begin
        w[i] = key[127 - 32*i -: 32];
    end
    rc = 8'h01;
    for (int i = 4; i < 44; i++) begin
        tmp = w[i-1];
        if (i % 4 == 0) begin
            tmp = {sboxByInverse(tmp[23:16]), sboxByInverse(tmp[15:8]),
                   sboxByInverse(tmp[7:0]), sboxByInverse(tmp[31:24])} ^ {rc, 24'h0};
            rc  = gfMul(rc, 8'h02);
        end
        w[i] = w[i-4] ^ tmp;
    end
    for (int i = 0; i < 16; i++) begin
        s[i] = pt[127 - 8*i -: 8] ^ w[i/4][31 - 8*(i%4) -: 8];
    end
    for (int r = 1; r <= 10; r++) begin
        // SubBytes with ShiftRows, byte i is row i%4 of column i/4
        for (int i = 0; i < 16; i++) begin
            t[i] = sboxByInverse(s[(i%4) + 4*(((i/4) + (i%4)) % 4)]);
        end
        for (int c = 0; c < 4; c++) begin
            if (r < 10) begin
                s[4*c]   = gfMul(t[4*c], 2) ^ gfMul(t[4*c+1], 3) ^ t[4*c+2] ^ t[4*c+3];
                s[4*c+1] = t[4*c] ^ gfMul(t[4*c+1], 2) ^ gfMul(t[4*c+2], 3) ^ t[4*c+3];
                s[4*c+2] = t[4*c] ^ t[4*c+1] ^ gfMul(t[4*c+2], 2) ^ gfMul(t[4*c+3], 3);
                s[4*c+3] = gfMul(t[4*c], 3) ^ t[4*c+1] ^ t[4*c+2] ^ gfMul(t[4*c+3], 2);
            end else begin
                for (int k = 0; k < 4; k++) begin
                    s[4*c+k] = t[4*c+k];
                end
            end
        end
        for (int i = 0; i < 16; i++) begin
            s[i] = s[i] ^ w[4*r + i/4][31 - 8*(i%4) -: 8];
        end
    end
    for (int i = 0; i < 16; i++) begin
        res[127 - 8*i -: 8] = s[i];
    end
    return res;
endfunction

// Lane block, counter wraps within its 64 bits
function automatic logic [127:0] counterBlock(input logic [63:0] base, input int lane);
    logic [63:0] sum;
    sum = base + 64'(lane);
    return {64'h0, sum};
endfunction

`endif

/* verif/tbKeystream.sv */
/*
 * Keystream top testbench, directed tests checked against
 * a behavioral AES model with a credit-returning consumer
 */
`timescale 1ns/1ps

module tbKeystream import aesPkg::*, streamPkg::*; ();

    localparam int          ClkPeriod     = 40;
    localparam int          TestCount     = 5;
    localparam int          KeyLoadCycles = 11;
    localparam int          FirstLatency  = 11;
    localparam logic [31:0] LfsrSeed      = 32'h7453_9b99;

    logic       Clock;
    logic       rstN;
    aesBlockT   key;
    logic       keyValid;
    logic       keyReady;
    ctrReqT     ctrIn;
    logic       ctrValid;
    logic       ctrReady;
    streamWordT strmOut;
    logic       strmValid;
    logic       creditReturn = 1'b0;

    // Scoreboard of accepted bases, oldest first
    logic [CtrBits-1:0] expQ [$];
    aesBlockT           curKey;
    int                 rxCount;
    // Credits held by the consumer, not yet returned
    int                 owed;
    int                 gapLeft;
    logic               holdCredits;
    logic               randomGaps;
    logic [31:0]        lfsrState;
    logic [31:0]        gapState;

    `include "aesModel.svh"

    keystreamTop i_dut (
        .Clock        (Clock),
        .rstN         (rstN),
        .key          (key),
        .keyValid     (keyValid),
        .keyReady     (keyReady),
        .ctrIn        (ctrIn),
        .ctrValid     (ctrValid),
        .ctrReady     (ctrReady),
        .strmOut      (strmOut),
        .strmValid    (strmValid),
        .creditReturn (creditReturn)
    );

    initial Clock = 1'b0;
    always #(ClkPeriod / 2) Clock = ~Clock;

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [63:0] takeBits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            v = {v[62:0], lfsrState[0]};
        end
        return v;
    endfunction

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic expectEqual(input logic [127:0] expected, input logic [127:0] actual,
                               input string what);
        if (expected !== actual) begin
            abortRun($sformatf("Mismatch at %0t: %s, expected %h, got %h",
                               $time, what, expected, actual));
        end
    endtask

    // Compare one released word with the oldest accepted base
    task automatic checkWord();
        logic [CtrBits-1:0] base;
        if (expQ.size() == 0) begin
            abortRun("A word was released with no counter request outstanding");
        end else begin
            base = expQ.pop_front();
            for (int j = 0; j < LaneCount; j++) begin
                expectEqual(encryptBlock(curKey, counterBlock(base, j)), strmOut.blocks[j],
                            $sformatf("word %0d lane %0d", rxCount, j));
            end
            expectEqual(128'(rxCount[SeqBits-1:0]), 128'(strmOut.seq), "sequence number");
            rxCount++;
            owed++;
        end
    endtask

    // Output monitor, mid-cycle sampling
    always @(negedge Clock) begin
        if (rstN && strmValid) begin
            checkWord();
        end
    end

    // Consumer hands credits back, optionally with random gaps
    always @(posedge Clock) begin
        #2;
        if (gapLeft > 0) begin
            creditReturn = 1'b0;
            gapLeft--;
        end else if (!holdCredits && owed > 0) begin
            creditReturn = 1'b1;
            owed--;
            if (randomGaps) begin
                gapState = lfsrNext(gapState);
                gapLeft  = int'(gapState[0]);
                gapState = lfsrNext(gapState);
                gapLeft  = 2 * gapLeft + int'(gapState[0]);
            end
        end else begin
            creditReturn = 1'b0;
        end
    end

    // ----------------------------------------
    // Bus tasks, entered and left just after a rising edge
    // ----------------------------------------
    task automatic sendBase(input logic [CtrBits-1:0] base);
        ctrIn.ctrBase = base;
        ctrValid      = 1'b1;
        @(negedge Clock);
        while (!ctrReady) begin
            @(negedge Clock);
        end
        expQ.push_back(base);
        @(posedge Clock);
        #2;
        ctrValid = 1'b0;
    endtask

    task automatic loadKey(input aesBlockT k);
        int cycles;
        key      = k;
        keyValid = 1'b1;
        @(negedge Clock);
        while (!keyReady) begin
            @(negedge Clock);
        end
        @(posedge Clock);
        #2;
        keyValid = 1'b0;
        curKey   = k;
        // Expander holds the key path for the whole schedule
        @(negedge Clock);
        cycles = 1;
        while (!keyReady) begin
            @(negedge Clock);
            cycles++;
        end
        expectEqual(128'(KeyLoadCycles), 128'(cycles), "key load cycles");
        @(posedge Clock);
        #2;
    endtask

    task automatic waitDrain();
        while (expQ.size() != 0 || owed != 0) begin
            @(posedge Clock);
            #2;
        end
        // Final credit counts on the next edge
        @(posedge Clock);
        #2;
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic knownAnswerTest();
        aesBlockT fipsKey;
        int       latency;
        fipsKey = 128'h000102030405060708090a0b0c0d0e0f;
        // FIPS-197 appendix C.1 vector through the model
        expectEqual(128'h69c4e0d86a7b0430d8cdb78070b4c55a,
                    encryptBlock(fipsKey, 128'h00112233445566778899aabbccddeeff),
                    "FIPS-197 model vector");
        loadKey(fipsKey);
        // Counter block reaches only the low half of the vector
        sendBase(64'h8899aabbccddeeff);
        latency = 0;
        while (!strmValid) begin
            @(negedge Clock);
            latency++;
        end
        expectEqual(128'(FirstLatency), 128'(latency), "first word latency");
        waitDrain();
    endtask

    task automatic laneCounterTest();
        randomGaps = 1'b1;
        for (int i = 0; i < 6; i++) begin
            sendBase(takeBits(CtrBits));
        end
        waitDrain();
        randomGaps = 1'b0;
    endtask

    task automatic streamingTest();
        logic [CtrBits-1:0] base;
        base = takeBits(CtrBits);
        for (int i = 0; i < 16; i++) begin
            sendBase(base + CtrBits'(i * LaneCount));
        end
        waitDrain();
    endtask

    task automatic backPressureTest();
        logic [CtrBits-1:0] base;
        logic [CtrBits-1:0] extra;
        int                 startRx;
        holdCredits = 1'b1;
        startRx     = rxCount;
        base        = takeBits(CtrBits);
        // Credits drain first, then every slot fills
        for (int i = 0; i < CreditMax + SlotCount; i++) begin
            sendBase(base + CtrBits'(i * LaneCount));
        end
        extra         = base + CtrBits'((CreditMax + SlotCount) * LaneCount);
        ctrIn.ctrBase = extra;
        ctrValid      = 1'b1;
        repeat (2 * FirstLatency) begin
            @(negedge Clock);
            expectEqual(128'(0), 128'(ctrReady), "ctrReady with every slot held");
        end
        expectEqual(128'(CreditMax), 128'(rxCount - startRx), "words without returned credits");
        @(posedge Clock);
        #2;
        holdCredits = 1'b0;
        sendBase(extra);
        waitDrain();
    endtask

    task automatic keyReloadTest();
        aesBlockT newKey;
        sendBase(takeBits(CtrBits));
        sendBase(takeBits(CtrBits));
        @(negedge Clock);
        expectEqual(128'(0), 128'(keyReady), "keyReady with blocks in flight");
        waitDrain();
        @(negedge Clock);
        expectEqual(128'(1), 128'(keyReady), "keyReady after drain");
        @(posedge Clock);
        #2;
        newKey[127:64] = takeBits(64);
        newKey[63:0]   = takeBits(64);
        loadKey(newKey);
        for (int i = 0; i < 4; i++) begin
            sendBase(takeBits(CtrBits));
        end
        waitDrain();
    endtask

    // ----------------------------------------
    // Main sequence and watchdog
    // ----------------------------------------
    initial begin
        rstN        = 1'b0;
        key         = '0;
        keyValid    = 1'b0;
        ctrIn       = '0;
        ctrValid    = 1'b0;
        curKey      = '0;
        rxCount     = 0;
        owed        = 0;
        gapLeft     = 0;
        holdCredits = 1'b0;
        randomGaps  = 1'b0;
        lfsrState   = LfsrSeed;
        gapState    = LfsrSeed;
        repeat (16) @(posedge Clock);
        #2;
        rstN = 1'b1;
        @(negedge Clock);
        expectEqual(128'(0), 128'(strmValid), "strmValid after reset");
        expectEqual(128'(1), 128'(keyReady), "keyReady after reset");
        expectEqual(128'(0), 128'(ctrReady), "ctrReady before a key");
        @(posedge Clock);
        #2;
        knownAnswerTest();
        laneCounterTest();
        streamingTest();
        backPressureTest();
        keyReloadTest();
        $display("Result: PASSED");
        $finish;
    end

    initial begin
        #(TestCount * 200 * ClkPeriod);
        abortRun("Timeout: the tests did not finish in the allotted time");
    end

endmodule

/* verilog/keystreamSlots.sv */
/*
 * Rotating slot array of AES lane cores, releases keystream
 * words in acceptance order under output credit control
 */
`timescale 1ns/1ps

module keystreamSlots import aesPkg::*, streamPkg::*; (
    input  logic       Clock,
    input  logic       rstN,
    input  ctrReqT     ctrIn,
    input  logic       ctrValid,
    input  logic       keyLoaded,
    input  logic       keyBusy,
    input  roundKeysT  roundKeys,
    input  logic       creditReturn,
    output logic       ctrReady,
    output logic       slotsEmpty,
    output streamWordT strmOut,
    output logic       strmValid
);

    logic [SlotIdxBits-1:0]                  inPtr;
    logic [SlotIdxBits-1:0]                  outPtr;
    logic [SlotCount-1:0]                    slotBusy;
    logic [SlotCount-1:0]                    slotLoad;
    logic [SlotCount-1:0]                    slotClear;
    logic [CreditBits-1:0]                   creditCnt;
    logic [SeqBits-1:0]                      seqCnt;
    logic                                    ctrAccept;
    logic [SlotCount-1:0][LaneCount-1:0]     laneDone;
    aesBlockT [SlotCount-1:0][LaneCount-1:0] laneResult;
    aesBlockT [LaneCount-1:0]                ctrBlock;

    // ----------------------------------------
    // Input side
    // ----------------------------------------
    // Pending request blocks a key load, so key and counter never cross
    assign slotsEmpty = !(|slotBusy) && !ctrValid;
    // Counters taken only while the key path is locked out
    assign ctrReady   = keyLoaded && keyBusy && !slotBusy[inPtr];
    assign ctrAccept  = ctrValid && ctrReady;

    // Lane j counts from base plus j, sum wraps at CtrBits
    always_comb begin
        for (int j = 0; j < LaneCount; j++) begin
            ctrBlock[j] = {{(AesBlockBits - CtrBits){1'b0}}, ctrIn.ctrBase + CtrBits'(j)};
        end
    end

    // ----------------------------------------
    // Output side
    // ----------------------------------------
    // Head slot finished on every lane and a credit in hand
    assign strmValid    = slotBusy[outPtr] && (&laneDone[outPtr]) && (creditCnt != '0);
    assign strmOut.blocks = laneResult[outPtr];
    assign strmOut.seq    = seqCnt;

    // Per-slot load and clear strobes
    always_comb begin
        for (int s = 0; s < SlotCount; s++) begin
            slotLoad[s]  = ctrAccept && (inPtr == SlotIdxBits'(s));
            slotClear[s] = strmValid && (outPtr == SlotIdxBits'(s));
        end
    end

    // ----------------------------------------
    // Pointers, busy flags, sequence
    // ----------------------------------------
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            inPtr    <= '0;
            outPtr   <= '0;
            slotBusy <= '0;
            seqCnt   <= '0;
        end else begin
            if (ctrAccept) begin
                inPtr <= (inPtr == SlotIdxBits'(SlotCount - 1)) ? '0 : inPtr + 1'b1;
            end
            if (strmValid) begin
                outPtr <= (outPtr == SlotIdxBits'(SlotCount - 1)) ? '0 : outPtr + 1'b1;
                seqCnt <= seqCnt + 1'b1;
            end
            // Load and clear never hit the same slot
            slotBusy <= (slotBusy | slotLoad) & ~slotClear;
        end
    end

    // Output credits, full after reset
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            creditCnt <= CreditBits'(CreditMax);
        end else begin
            case ({strmValid, creditReturn})
                2'b10:   creditCnt <= creditCnt - 1'b1;
                2'b01:   creditCnt <= creditCnt + 1'b1;
                default: creditCnt <= creditCnt;
            endcase
        end
    end

    // ----------------------------------------
    // Lane cores
    // ----------------------------------------
    for (genvar s = 0; s < SlotCount; s++) begin : genSlot
        for (genvar j = 0; j < LaneCount; j++) begin : genLane
            aesCipherCore core (
                .Clock     (Clock),
                .rstN      (rstN),
                .load      (slotLoad[s]),
                .clear     (slotClear[s]),
                .block     (ctrBlock[j]),
                .roundKeys (roundKeys),
                .done      (laneDone[s][j]),
                .result    (laneResult[s][j])
            );
        end
    end

    // Consumer never returns more than it was granted
    creditInRange: assert property (
        @(posedge Clock) disable iff (!rstN)
        creditCnt <= CreditBits'(CreditMax)
    );

    // Lanes of one slot start together and finish together
    lanesInLockstep: assert property (
        @(posedge Clock) disable iff (!rstN)
        slotBusy[outPtr] |-> (&laneDone[outPtr]) || !(|laneDone[outPtr])
    );

endmodule

/* verilog/keystreamTop.sv */
/*
 * AES-128 counter-mode keystream generator top,
 * key expander feeding the rotating slot array
 */
`timescale 1ns/1ps

module keystreamTop import aesPkg::*, streamPkg::*; (
    input  logic       Clock,
    input  logic       rstN,
    input  aesBlockT   key,
    input  logic       keyValid,
    output logic       keyReady,
    input  ctrReqT     ctrIn,
    input  logic       ctrValid,
    output logic       ctrReady,
    output streamWordT strmOut,
    output logic       strmValid,
    input  logic       creditReturn
);

    logic      keyLoaded;
    logic      keyBusy;
    logic      slotsEmpty;
    roundKeysT roundKeys;

    // Key path closed, round keys safe to use
    assign keyBusy = !keyReady;

    aesKeyExpand keyExpand (
        .Clock      (Clock),
        .rstN       (rstN),
        .key        (key),
        .keyValid   (keyValid),
        .slotsEmpty (slotsEmpty),
        .keyReady   (keyReady),
        .keyLoaded  (keyLoaded),
        .roundKeys  (roundKeys)
    );

    keystreamSlots slotArray (
        .Clock        (Clock),
        .rstN         (rstN),
        .ctrIn        (ctrIn),
        .ctrValid     (ctrValid),
        .keyLoaded    (keyLoaded),
        .keyBusy      (keyBusy),
        .roundKeys    (roundKeys),
        .creditReturn (creditReturn),
        .ctrReady     (ctrReady),
        .slotsEmpty   (slotsEmpty),
        .strmOut      (strmOut),
        .strmValid    (strmValid)
    );

endmodule
